//--- source/cipher_params_pkg.sv
// Widths, rotations and table file of the block cipher, imported by RTL and testbench alike
package cipher_params_pkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Data path widths
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        parameter int BLOCK_W = 64;             // Cipher block
        parameter int KEY_W   = 128;            // Master and working key
        parameter int BYTE_W  = 8;              // Substitution box lane

        // Round counter, enough for up to 31 rounds
        parameter int ROUND_W = 5;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Round function constants
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        parameter int KEY_ROT = 61;             // Working key left rotation per round
        parameter int MIX_ROT = 3;              // High half left rotation in the mix

        // Substitution table, 256 bytes in hex, path relative to the run directory
        parameter string SBOX_FILE = "source/sbox_table.hex";

endpackage

//--- source/cipher_state_pkg.sv
// Cipher state word type, seen as byte lanes by the substitution layer and as halves by the mix
package cipher_state_pkg;

        import cipher_params_pkg::*;

        // Two 32-bit words, hi is the upper half of the block
        typedef struct packed {
                logic [BLOCK_W/2-1:0] hi;
                logic [BLOCK_W/2-1:0] lo;
        } cipher_halves_t;

        // One 64-bit state, decoded both ways in every round
        typedef union packed {
                logic [BLOCK_W/BYTE_W-1:0][BYTE_W-1:0] bytes;   // Lane 0 is the low byte
                cipher_halves_t                        halves;
        } cipher_state_t;

endpackage

//--- source/diy_sbox.sv
// Combinational 8-bit substitution ROM filled from the hex table, used by datapath and key schedule
module diy_sbox
        import cipher_params_pkg::*;
(
        input  logic [BYTE_W-1:0] sbox_in,
        output logic [BYTE_W-1:0] sbox_out
);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Table storage
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        logic [BYTE_W-1:0] rom [0:(1<<BYTE_W)-1];

        initial begin
                $readmemh(SBOX_FILE, rom);      // 16 entries per line, address order
        end

        // Pure lookup, no clock
        assign sbox_out = rom[sbox_in];

endmodule

//--- source/key_schedule.sv
// Key schedule holding the master and working keys and handing one round key per round
module key_schedule
        import cipher_params_pkg::*;
(
        input  logic               clk,
        input  logic               rst_n,
        input  logic [KEY_W-1:0]   key,
        input  logic               key_write,
        input  logic               load,
        input  logic               round_en,
        input  logic [ROUND_W-1:0] round_idx,
        output logic [BLOCK_W-1:0] round_key
);

        logic [KEY_W-1:0]  master_q;            // Written by key_write
        logic [KEY_W-1:0]  work_q;              // Updated once per round
        logic [KEY_W-1:0]  rot_key;
        logic [KEY_W-1:0]  next_key;
        logic [BYTE_W-1:0] top_sub;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Round update: rotate, substitute top byte, add round number
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        assign rot_key = {work_q[KEY_W-KEY_ROT-1:0], work_q[KEY_W-1 -: KEY_ROT]};

        diy_sbox key_sbox_inst (
                .sbox_in  (rot_key[KEY_W-1 -: BYTE_W]),
                .sbox_out (top_sub)
        );

        always_comb begin
                next_key = rot_key;
                next_key[KEY_W-1 -: BYTE_W] = top_sub;
                next_key[BYTE_W-1:0] = rot_key[BYTE_W-1:0] ^
                                       {{(BYTE_W-ROUND_W){1'b0}}, round_idx};
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Key registers
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        master_q <= '0;         // No key material survives reset
                        work_q   <= '0;
                end else begin
                        if (key_write)
                                master_q <= key;
                        if (load)
                                work_q <= master_q;     // Fresh copy per block
                        else if (round_en)
                                work_q <= next_key;
                end
        end

        // Round key is the upper half of the working key
        assign round_key = work_q[KEY_W-1 -: BLOCK_W];

endmodule

//--- source/round_datapath.sv
// Round datapath with the state register, key addition, byte substitution, half mix and output
module round_datapath
        import cipher_params_pkg::*;
        import cipher_state_pkg::*;
(
        input  logic               clk,
        input  logic               rst_n,
        input  logic [BLOCK_W-1:0] block_in,
        input  logic               load,
        input  logic               round_en,
        input  logic               finish,
        input  logic [BLOCK_W-1:0] round_key,
        output logic [BLOCK_W-1:0] block_out
);

        localparam int NUM_LANES = BLOCK_W / BYTE_W;
        localparam int HALF_W    = BLOCK_W / 2;

        cipher_state_t                     state_q;
        cipher_state_t                     keyed;
        cipher_state_t                     subst;
        cipher_state_t                     mixed;
        logic [NUM_LANES-1:0][BYTE_W-1:0]  sub_lanes;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Key addition and substitution layer
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        assign keyed = state_q ^ round_key;

        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
                diy_sbox lane_sbox_inst (
                        .sbox_in  (keyed.bytes[i]),
                        .sbox_out (sub_lanes[i])
                );
        end

        assign subst.bytes = sub_lanes;

        // Half mix, Feistel-like swap with a rotated high half
        always_comb begin
                mixed.halves.hi = subst.halves.lo ^
                        {subst.halves.hi[HALF_W-MIX_ROT-1:0], subst.halves.hi[HALF_W-1 -: MIX_ROT]};
                mixed.halves.lo = subst.halves.hi;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Registers
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge clk) begin
                if (load)
                        state_q <= block_in;
                else if (round_en)
                        state_q <= mixed;
        end

        always_ff @(posedge clk) begin
                if (!rst_n)
                        block_out <= '0;
                else if (finish)
                        block_out <= state_q ^ round_key;  // Final whitening
        end

endmodule

//--- source/cipher_control.sv
// Control FSM with round counter, sequencing load, the rounds and the finish of each block
module cipher_control
        import cipher_params_pkg::*;
#(
        parameter int ROUNDS = 8
) (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               start,
        input  logic               key_load,
        output logic               key_write,
        output logic               load,
        output logic               round_en,
        output logic [ROUND_W-1:0] round_idx,
        output logic               finish,
        output logic               busy,
        output logic               done
);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // State encoding
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        localparam logic [1:0] S_IDLE   = 2'd0;
        localparam logic [1:0] S_ROUND  = 2'd1;
        localparam logic [1:0] S_FINISH = 2'd2;

        localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(ROUNDS);

        logic [1:0]         state_q;
        logic [ROUND_W-1:0] round_q;
        logic               idle;

        assign idle = (state_q == S_IDLE);

        // Strobes seen by datapath and key schedule
        assign load      = idle && start;       // Start cycle only
        assign key_write = idle && key_load;    // Key is frozen while busy
        assign round_en  = (state_q == S_ROUND);
        assign finish    = (state_q == S_FINISH);
        assign busy      = !idle;
        assign round_idx = round_q;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // FSM and round counter
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state_q <= S_IDLE;
                        round_q <= '0;
                        done    <= 1'b0;
                end else begin
                        done <= finish;         // Lines up with block_out update
                        case (state_q)
                                S_IDLE: begin
                                        if (start) begin
                                                state_q <= S_ROUND;
                                                round_q <= ROUND_W'(1);
                                        end
                                end
                                S_ROUND: begin
                                        if (round_q == LAST_ROUND)
                                                state_q <= S_FINISH;
                                        else
                                                round_q <= round_q + 1'b1;
                                end
                                default: begin
                                        state_q <= S_IDLE;   // Finish lasts one cycle
                                        round_q <= '0;
                                end
                        endcase
                end
        end

endmodule

//--- source/block_cipher_top.sv
// Top level of the block cipher core, wiring control, key schedule and round datapath
module block_cipher_top
        import cipher_params_pkg::*;
#(
        parameter int ROUNDS = 8                // 1 to 31
) (
        input  logic               clk,
        input  logic               rst_n,
        input  logic [KEY_W-1:0]   key,
        input  logic               key_load,
        input  logic [BLOCK_W-1:0] block_in,
        input  logic               start,
        output logic [BLOCK_W-1:0] block_out,
        output logic               busy,
        output logic               done
);

        logic               key_write;
        logic               load;
        logic               round_en;
        logic [ROUND_W-1:0] round_idx;
        logic               finish;
        logic [BLOCK_W-1:0] round_key;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Sequencing
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        cipher_control #(
                .ROUNDS (ROUNDS)
        ) cipher_control_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (start),
                .key_load  (key_load),
                .key_write (key_write),
                .load      (load),
                .round_en  (round_en),
                .round_idx (round_idx),
                .finish    (finish),
                .busy      (busy),
                .done      (done)
        );

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Key path and data path
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        key_schedule key_schedule_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .key       (key),
                .key_write (key_write),
                .load      (load),
                .round_en  (round_en),
                .round_idx (round_idx),
                .round_key (round_key)
        );

        round_datapath round_datapath_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .block_in  (block_in),
                .load      (load),
                .round_en  (round_en),
                .finish    (finish),
                .round_key (round_key),
                .block_out (block_out)
        );

endmodule

//--- sim/cipher_model.svh
// Reference model of the block cipher, included inside the testbench module after ROUNDS
`ifndef CIPHER_MODEL_SVH
`define CIPHER_MODEL_SVH

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Substitution table
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        logic [BYTE_W-1:0] model_sbox [0:(1<<BYTE_W)-1];

        task automatic load_sbox_table();
                $readmemh(SBOX_FILE, model_sbox);       // Same file as the ROM
        endtask

        function automatic logic [BYTE_W-1:0] sub_byte(input logic [BYTE_W-1:0] b);
                return model_sbox[b];
        endfunction

        // Every lane through the table
        function automatic cipher_state_t sub_layer(input cipher_state_t s);
                cipher_state_t r;
                for (int i = 0; i < BLOCK_W / BYTE_W; i++) begin
                        r.bytes[i] = sub_byte(s.bytes[i]);
                end
                return r;
        endfunction

        // New hi is lo XOR rotated hi, new lo is old hi
        function automatic cipher_state_t half_mix(input cipher_state_t s);
                cipher_state_t          r;
                logic [BLOCK_W/2-1:0]   hi_rot;
                hi_rot = (s.halves.hi << MIX_ROT) | (s.halves.hi >> (BLOCK_W / 2 - MIX_ROT));
                r.halves.hi = s.halves.lo ^ hi_rot;
                r.halves.lo = s.halves.hi;
                return r;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Key schedule and full encryption
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        function automatic logic [KEY_W-1:0] key_step(input logic [KEY_W-1:0] k,
                                                       input int r);
                logic [KEY_W-1:0] n;
                n = (k << KEY_ROT) | (k >> (KEY_W - KEY_ROT));
                n[KEY_W-1 -: BYTE_W] = sub_byte(n[KEY_W-1 -: BYTE_W]);
                n[BYTE_W-1:0] = n[BYTE_W-1:0] ^ r[BYTE_W-1:0];      // Round constant
                return n;
        endfunction

        function automatic logic [BLOCK_W-1:0] encrypt_block(input logic [KEY_W-1:0] k,
                                                              input logic [BLOCK_W-1:0] blk);
                cipher_state_t    s;
                logic [KEY_W-1:0] wk;
                s = blk;
                wk = k;
                for (int r = 1; r <= ROUNDS; r++) begin
                        s = s ^ wk[KEY_W-1 -: BLOCK_W];
                        s = sub_layer(s);
                        s = half_mix(s);
                        wk = key_step(wk, r);
                end
                return s ^ wk[KEY_W-1 -: BLOCK_W];     // Whitening with the last key
        endfunction

`endif

//--- sim/tb_block_cipher.sv
// Testbench for the block cipher core that checks random keys and blocks against the model
module tb_block_cipher
        import cipher_params_pkg::*;
        import cipher_state_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int ROUNDS = 8;
        localparam int TIMEOUT_CYCLES = 200 * (ROUNDS + 4) + 200;

        logic               clk;
        logic               rst_n;
        logic [KEY_W-1:0]   key;
        logic               key_load;
        logic [BLOCK_W-1:0] block_in;
        logic               start;
        logic [BLOCK_W-1:0] block_out;
        logic               busy;
        logic               done;

        int value_errors   = 0;
        int other_errors   = 0;
        int cycle_count    = 0;
        int done_seen      = 0;
        int expected_dones = 0;

        logic [31:0]        lfsr_state = 32'hcb85_7c08;
        logic [BLOCK_W-1:0] last_out   = '0;        // Result block_out must hold
        logic [KEY_W-1:0]   k;
        logic [KEY_W-1:0]   k_alt;
        logic [BLOCK_W-1:0] b;
        logic [BLOCK_W-1:0] cur_blk;
        logic [BLOCK_W-1:0] nxt_blk;

        `include "cipher_model.svh"

        block_cipher_top #(
                .ROUNDS (ROUNDS)
        ) block_cipher_top_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .key       (key),
                .key_load  (key_load),
                .block_in  (block_in),
                .start     (start),
                .block_out (block_out),
                .busy      (busy),
                .done      (done)
        );

        always #20 clk = ~clk;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Random source
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'h8020_0003;        // Taps 32, 22, 2, 1
                return s >> 1;
        endfunction

        function automatic logic random_bit();
                lfsr_state = lfsr_next(lfsr_state);
                return lfsr_state[0];
        endfunction

        function automatic logic [KEY_W-1:0] random_key();
                logic [KEY_W-1:0] v;
                for (int i = 0; i < KEY_W; i++) begin
                        v[i] = random_bit();
                end
                return v;
        endfunction

        function automatic logic [BLOCK_W-1:0] random_block();
                logic [BLOCK_W-1:0] v;
                for (int i = 0; i < BLOCK_W; i++) begin
                        v[i] = random_bit();
                end
                return v;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Checks and reporting
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic check_value(input string name, input logic [BLOCK_W-1:0] exp,
                                   input logic [BLOCK_W-1:0] got);
                assert (got === exp) else begin
                        value_errors++;
                        $display("** Error %s: expected %0h, actual %0h", name, exp, got);
                end
        endtask

        task automatic check_true(input bit cond, input string what);
                assert (cond) else begin
                        other_errors++;
                        $display("Failure at cycle %0d: %s", cycle_count, what);
                end
        endtask

        task automatic report_and_finish();
                $display("Summary: %0d value errors, %0d other errors",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("Regression passed");
                else
                        $display("Regression failed");
                $finish;
        endtask

        always @(posedge clk) begin
                cycle_count++;
                if (cycle_count > TIMEOUT_CYCLES) begin
                        other_errors++;
                        $display("Timeout after %0d cycles, a block never completed", cycle_count);
                        report_and_finish();
                end
        end

        always @(negedge clk) begin
                if (done)
                        done_seen++;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Stimulus tasks
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic load_key(input logic [KEY_W-1:0] new_key);
                @(posedge clk);
                key      <= new_key;
                key_load <= 1'b1;
                @(posedge clk);
                key_load <= 1'b0;
        endtask

        // Returns right after the edge that samples start
        task automatic begin_block(input logic [BLOCK_W-1:0] blk);
                @(posedge clk);
                block_in <= blk;
                start    <= 1'b1;
                @(posedge clk);
                start    <= 1'b0;
        endtask

        // Counts cycles from the start edge while busy and the old output must hold
        task automatic wait_done(input string name, input logic [BLOCK_W-1:0] exp);
                int lat;
                lat = 0;
                expected_dones++;
                @(negedge clk);
                while (!done && lat <= ROUNDS + 3) begin
                        check_true(busy, "busy low before done");
                        check_value({name, " hold"}, last_out, block_out);
                        lat++;
                        @(negedge clk);
                end
                check_true(done, "done never arrived");
                check_value({name, " latency"}, 64'(ROUNDS + 1), 64'(lat));
                check_value(name, exp, block_out);
                last_out = exp;
        endtask

        // Extra starts with new data that all land while busy
        task automatic pulse_starts();
                repeat (ROUNDS / 2) begin
                        @(posedge clk);
                        block_in <= random_block();
                        start    <= 1'b1;
                        @(posedge clk);
                        start    <= 1'b0;
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Test sequence
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        initial begin
                clk      = 1'b0;
                rst_n    = 1'b0;
                key      = '0;
                key_load = 1'b0;
                block_in = '0;
                start    = 1'b0;
                load_sbox_table();
                repeat (3) @(posedge clk);
                rst_n <= 1'b1;

                @(negedge clk);
                check_true(!busy, "busy high after reset");
                check_true(!done, "done high after reset");
                check_value("reset", '0, block_out);

                for (int n = 0; n < 150; n++) begin
                        k = random_key();
                        b = random_block();
                        load_key(k);
                        begin_block(b);
                        wait_done("random_encrypt", encrypt_block(k, b));
                end

                k = random_key();
                b = random_block();
                load_key(k);
                begin_block(b);
                fork
                        wait_done("start_while_busy", encrypt_block(k, b));
                        pulse_starts();
                join
                repeat (ROUNDS + 2) begin
                        @(negedge clk);
                        check_true(!done, "extra done after a start during busy");
                end

                k     = random_key();
                k_alt = random_key();
                b     = random_block();
                load_key(k);
                begin_block(b);
                fork
                        wait_done("key_load_busy", encrypt_block(k, b));
                        begin
                                @(posedge clk);
                                load_key(k_alt);        // Must not reach the master key
                        end
                join
                b = random_block();
                begin_block(b);
                wait_done("key_kept", encrypt_block(k, b));
                k = random_key();
                b = random_block();
                load_key(k);
                begin_block(b);
                wait_done("key_load_idle", encrypt_block(k, b));

                repeat (6) begin
                        @(negedge clk);
                        check_value("output_hold", last_out, block_out);
                        check_true(!done, "done pulsed while idle");
                        check_true(!busy, "busy high while idle");
                end

                // Start stays high so each new block is taken right after done
                k = random_key();
                load_key(k);
                nxt_blk = random_block();
                @(posedge clk);
                block_in <= nxt_blk;
                start    <= 1'b1;
                for (int i = 0; i < 40; i++) begin
                        cur_blk = nxt_blk;
                        nxt_blk = random_block();
                        @(posedge clk);
                        if (i < 39)
                                block_in <= nxt_blk;
                        else
                                start <= 1'b0;
                        wait_done("back_to_back", encrypt_block(k, cur_blk));
                end

                repeat (2) @(posedge clk);
                check_true(done_seen == expected_dones, "done pulse count differs from starts");
                report_and_finish();
        end

endmodule

//--- source/sbox_table.hex
// 256 substitution bytes in address order, 16 per line, column is the low address nibble
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16

//--- compile.f
+incdir+sim
source/cipher_params_pkg.sv
source/cipher_state_pkg.sv
source/diy_sbox.sv
source/key_schedule.sv
source/round_datapath.sv
source/cipher_control.sv
source/block_cipher_top.sv
sim/tb_block_cipher.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it from the project root and look for the pass line
cd "$(dirname "$0")" \
        && verilator --binary --timing --assert -j 0 \
                --top-module tb_block_cipher -f compile.f \
        && ./obj_dir/Vtb_block_cipher | tee /dev/stderr \
                | grep -F "Regression passed" > /dev/null \
        && echo "Simulation OK" \
        || { echo "Simulation did not pass"; exit 1; }
